/* verilog/fetch_pkg.sv */
package fetch_pkg;

  localparam int addr_w       = 6;     // logical and physical word address
  localparam int word_w       = 16;
  localparam int page_words   = 8;
  localparam int off_w        = $clog2(page_words);  // offset inside a page
  localparam int num_segments = 8;
  localparam int seg_w        = 3;
  localparam int trace_depth  = 16;
  localparam int trace_ptr_w  = $clog2(trace_depth);
  localparam int clks_per_bit = 16;    // short bit period for sim
  localparam int bit_cnt_w    = $clog2(clks_per_bit);

  // wishbone register map
  localparam logic [7:0] ram_base        = 8'h00;  // 0x00..0x3f program words
  localparam logic [7:0] seg_base        = 8'h40;  // 0x40..0x47 segment entries
  localparam logic [7:0] reg_start_seg   = 8'h48;
  localparam logic [7:0] reg_fetch_start = 8'h49;
  localparam logic [7:0] reg_fetch_end   = 8'h4a;
  localparam logic [7:0] reg_ctrl        = 8'h4b;  // wr bit0 go, rd bit0 busy bit1 fault

  // opcodes in word1[15:8]
  localparam logic [7:0] op_jmp     = 8'h01;
  localparam logic [7:0] op_ram2reg = 8'h02;
  localparam logic [7:0] op_reg2ram = 8'h03;
  localparam logic [7:0] op_num2reg = 8'h04;
  localparam logic [7:0] op_proc    = 8'h0c;

  // trace letters
  localparam logic [7:0] chr_go      = "G";
  localparam logic [7:0] chr_end     = "E";
  localparam logic [7:0] chr_fault   = "F";
  localparam logic [7:0] chr_jmp     = "J";
  localparam logic [7:0] chr_ram2reg = "L";
  localparam logic [7:0] chr_reg2ram = "S";
  localparam logic [7:0] chr_num2reg = "N";
  localparam logic [7:0] chr_proc    = "P";
  localparam logic [7:0] chr_other   = "X";

  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [7:0]        adr;
    logic [word_w-1:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic              ack;
    logic [word_w-1:0] dat;
  } wb_rsp_t;

  // page 0 marks an empty segment
  typedef struct packed {
    logic [seg_w-1:0] next_seg;
    logic [seg_w-1:0] page;
  } seg_entry_t;

  typedef seg_entry_t [num_segments-1:0] seg_table_t;

  typedef struct packed {
    seg_table_t        seg_tab;
    logic [seg_w-1:0]  start_seg;
    logic [addr_w-1:0] fetch_start;
    logic [addr_w-1:0] fetch_end;
    logic              go;        // one cycle
  } mmu_cfg_t;

  typedef struct packed {
    logic              en;
    logic [addr_w-1:0] addr;
    logic [word_w-1:0] data;
  } ram_wr_t;

  typedef struct packed {
    logic              valid;
    logic [addr_w-1:0] addr;   // logical
  } tr_req_t;

  typedef struct packed {
    logic              done;
    logic              fault;
    logic [addr_w-1:0] addr;   // physical
  } tr_rsp_t;

  typedef struct packed {
    logic [addr_w-1:0] pc;
    logic [word_w-1:0] word1;
    logic [word_w-1:0] word2;
  } insn_t;

  typedef struct packed {
    logic       valid;
    logic [7:0] chr;
  } trace_push_t;

endpackage

/* verilog/mmu_config.sv */
`timescale 1ns/10ps

module mmu_config (
  input  logic               clk,
  input  logic               rst_n,
  input  fetch_pkg::wb_req_t wb_req,
  output fetch_pkg::wb_rsp_t wb_rsp,
  input  logic               busy,
  input  logic               fault,
  output fetch_pkg::mmu_cfg_t cfg,
  output fetch_pkg::ram_wr_t ram_wr
);
  import fetch_pkg::*;

  logic              stb_new;  // first cycle of a strobe
  logic              wr_new;
  logic              hit_ram;
  logic              hit_seg;
  logic [word_w-1:0] rd_mux;

  assign stb_new = wb_req.cyc && wb_req.stb && !wb_rsp.ack;
  assign wr_new  = stb_new && wb_req.we;
  assign hit_ram = wb_req.adr[7:6] == ram_base[7:6];
  assign hit_seg = wb_req.adr[7:3] == seg_base[7:3];

  // program words go straight to the ram, dropped while fetching
  assign ram_wr.en   = wr_new && hit_ram && !busy;
  assign ram_wr.addr = wb_req.adr[addr_w-1:0];
  assign ram_wr.data = wb_req.dat;

  always_comb begin
    rd_mux = '0;  // program memory reads as zero
    if (hit_seg) begin
      rd_mux = word_w'(cfg.seg_tab[wb_req.adr[seg_w-1:0]]);
    end else begin
      case (wb_req.adr)
        reg_start_seg:   rd_mux = word_w'(cfg.start_seg);
        reg_fetch_start: rd_mux = word_w'(cfg.fetch_start);
        reg_fetch_end:   rd_mux = word_w'(cfg.fetch_end);
        reg_ctrl:        rd_mux = word_w'({fault, busy});
        default:         rd_mux = '0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_rsp.ack      <= 1'b0;
      cfg.go          <= 1'b0;
      cfg.seg_tab     <= '0;
      cfg.start_seg   <= '0;
      cfg.fetch_start <= '0;
      cfg.fetch_end   <= '0;
    end else begin
      wb_rsp.ack <= stb_new;  // one cycle after strobe seen
      cfg.go     <= wr_new && wb_req.adr == reg_ctrl && wb_req.dat[0] && !busy;
      if (stb_new) begin
        wb_rsp.dat <= rd_mux;
      end
      if (wr_new) begin
        if (hit_seg) begin
          cfg.seg_tab[wb_req.adr[seg_w-1:0]] <= wb_req.dat[2*seg_w-1:0];
        end
        case (wb_req.adr)
          reg_start_seg:   cfg.start_seg   <= wb_req.dat[seg_w-1:0];
          reg_fetch_start: cfg.fetch_start <= wb_req.dat[addr_w-1:0];
          reg_fetch_end:   cfg.fetch_end   <= wb_req.dat[addr_w-1:0];
          default:         ;
        endcase
      end
    end
  end

  // master must still hold the strobe when ack comes back
  a_ack_in_cycle : assert property (@(posedge clk) disable iff (!rst_n)
    wb_rsp.ack |-> wb_req.cyc && wb_req.stb);

endmodule

/* verilog/mmu_walker.sv */
`timescale 1ns/10ps

module mmu_walker (
  input  logic                clk,
  input  logic                rst_n,
  input  fetch_pkg::mmu_cfg_t cfg,
  input  fetch_pkg::tr_req_t  req,
  output fetch_pkg::tr_rsp_t  rsp
);
  import fetch_pkg::*;

  logic             walking;   // chain search running
  logic [seg_w-1:0] cur_seg;
  logic [seg_w:0]   hops;      // hops taken to reach cur_seg
  logic [seg_w-1:0] req_page;
  logic [off_w-1:0] req_off;
  seg_entry_t       start_ent;
  seg_entry_t       cur_ent;

  assign req_page  = req.addr[addr_w-1:off_w];  // page is a plain slice
  assign req_off   = req.addr[off_w-1:0];
  assign start_ent = cfg.seg_tab[cfg.start_seg];
  assign cur_ent   = cfg.seg_tab[cur_seg];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      walking   <= 1'b0;
      cur_seg   <= '0;
      hops      <= '0;
      rsp.done  <= 1'b0;
      rsp.fault <= 1'b0;
    end else begin
      rsp.done  <= 1'b0;
      rsp.fault <= 1'b0;
      if (walking) begin
        if (cur_ent.page == req_page) begin
          walking  <= 1'b0;
          rsp.done <= 1'b1;
          rsp.addr <= {cur_seg, req_off};  // seg * page_words + offset
        end else if (cur_ent.next_seg == cur_seg ||
                     hops == (seg_w + 1)'(num_segments)) begin
          // end of chain or runaway loop
          walking   <= 1'b0;
          rsp.done  <= 1'b1;
          rsp.fault <= 1'b1;
        end else begin
          cur_seg <= cur_ent.next_seg;  // one hop per cycle
          hops    <= hops + 1'b1;
        end
      end else if (req.valid && !rsp.done) begin  // skip the held valid in done cycle
        if (req_page == '0) begin
          rsp.done <= 1'b1;  // page 0 lives in the start segment
          rsp.addr <= {cfg.start_seg, req_off};
        end else if (start_ent.next_seg == cfg.start_seg) begin
          rsp.done  <= 1'b1;  // single segment chain
          rsp.fault <= 1'b1;
        end else begin
          walking <= 1'b1;
          cur_seg <= start_ent.next_seg;  // first hop
          hops    <= 1;
        end
      end
    end
  end

  // a result only answers a request held since before it
  a_done_has_req : assert property (@(posedge clk) disable iff (!rst_n)
    rsp.done |-> req.valid && $past(req.valid));

endmodule

/* verilog/program_ram.sv */
`timescale 1ns/10ps

module program_ram (
  input  logic                         clk,
  input  fetch_pkg::ram_wr_t           wr,
  input  logic [fetch_pkg::addr_w-1:0] rd_addr,
  output logic [fetch_pkg::word_w-1:0] rd_data
);
  import fetch_pkg::*;

  logic [word_w-1:0] mem [2**addr_w];  // 64 program words

  // write from the wishbone side
  always_ff @(posedge clk) begin
    if (wr.en) begin
      mem[wr.addr] <= wr.data;
    end
  end

  // registered read, data one cycle after address
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

/* verilog/insn_fetcher.sv */
`timescale 1ns/10ps

module insn_fetcher (
  input  logic                         clk,
  input  logic                         rst_n,
  input  fetch_pkg::mmu_cfg_t          cfg,
  output fetch_pkg::tr_req_t           tr_req,
  input  fetch_pkg::tr_rsp_t           tr_rsp,
  output logic [fetch_pkg::addr_w-1:0] rd_addr,
  input  logic [fetch_pkg::word_w-1:0] rd_data,
  output fetch_pkg::insn_t             insn,
  output logic                         insn_valid,
  input  logic                         insn_ready,
  output fetch_pkg::trace_push_t       trace,
  input  logic                         trace_full,
  output logic                         busy,
  output logic                         fault
);
  import fetch_pkg::*;

  typedef enum logic [3:0] {
    S_IDLE, S_GO, S_TR1, S_RD1, S_TR2, S_RD2, S_HOLD, S_OUT, S_END, S_FAULT
  } state_t;

  state_t            state;
  logic [addr_w-1:0] pc;

  function automatic logic [7:0] op_letter(input logic [7:0] op);
    case (op)
      op_jmp:     return chr_jmp;
      op_ram2reg: return chr_ram2reg;
      op_reg2ram: return chr_reg2ram;
      op_num2reg: return chr_num2reg;
      op_proc:    return chr_proc;
      default:    return chr_other;
    endcase
  endfunction

  // valid held through the done cycle
  assign tr_req.valid = state == S_TR1 || state == S_TR2;
  assign tr_req.addr  = (state == S_TR2) ? pc + 1'b1 : pc;
  assign rd_addr      = tr_rsp.addr;  // read issued in the done cycle
  assign insn_valid   = state == S_OUT;

  always_comb begin
    trace.valid = 1'b0;
    trace.chr   = chr_other;
    case (state)
      S_GO: begin
        trace.valid = !trace_full;
        trace.chr   = chr_go;
      end
      S_OUT: begin
        trace.valid = insn_ready;  // letter goes with the handoff
        trace.chr   = op_letter(insn.word1[15:8]);
      end
      S_END: begin
        trace.valid = !trace_full;
        trace.chr   = chr_end;
      end
      S_FAULT: begin
        trace.valid = !trace_full;
        trace.chr   = chr_fault;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= S_IDLE;
      pc    <= '0;
      busy  <= 1'b0;
      fault <= 1'b0;
    end else begin
      case (state)
        S_IDLE: if (cfg.go) begin
          pc    <= cfg.fetch_start;
          busy  <= 1'b1;
          fault <= 1'b0;
          state <= S_GO;
        end
        S_GO:  if (!trace_full) state <= S_TR1;
        S_TR1: if (tr_rsp.done) state <= tr_rsp.fault ? S_FAULT : S_RD1;
        S_RD1: state <= S_TR2;  // word1 captured
        S_TR2: if (tr_rsp.done) state <= tr_rsp.fault ? S_FAULT : S_RD2;
        S_RD2: state <= S_HOLD;
        S_HOLD: if (!trace_full) state <= S_OUT;  // room for the letter
        S_OUT: if (insn_ready) begin
          if (pc >= cfg.fetch_end) begin
            state <= S_END;
          end else begin
            pc    <= pc + 2'd2;
            state <= S_TR1;
          end
        end
        S_END: if (!trace_full) begin
          busy  <= 1'b0;
          state <= S_IDLE;
        end
        S_FAULT: if (!trace_full) begin
          fault <= 1'b1;
          busy  <= 1'b0;
          state <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // pair payload, only loaded while not presented
  always_ff @(posedge clk) begin
    if (state == S_RD1) begin
      insn.pc    <= pc;
      insn.word1 <= rd_data;
    end
    if (state == S_RD2) insn.word2 <= rd_data;
  end

  a_insn_stable : assert property (@(posedge clk) disable iff (!rst_n)
    insn_valid && !insn_ready |=> insn_valid && $stable(insn));

endmodule

/* verilog/uart_trace.sv */
`timescale 1ns/10ps

module uart_trace (
  input  logic                   clk,
  input  logic                   rst_n,
  input  fetch_pkg::trace_push_t push,
  output logic                   full,
  output logic                   tx
);
  import fetch_pkg::*;

  logic [7:0]             fifo [trace_depth];
  logic [trace_ptr_w:0]   wr_ptr;   // extra bit tells full from empty
  logic [trace_ptr_w:0]   rd_ptr;
  logic                   empty;
  logic                   pop;
  logic                   tx_busy;  // frame on the line
  logic [9:0]             frame;    // stop, data, start
  logic [3:0]             bit_idx;
  logic [bit_cnt_w-1:0]   clk_cnt;
  logic                   bit_end;

  assign empty   = wr_ptr == rd_ptr;
  assign full    = wr_ptr[trace_ptr_w] != rd_ptr[trace_ptr_w] &&
                   wr_ptr[trace_ptr_w-1:0] == rd_ptr[trace_ptr_w-1:0];
  assign pop     = !tx_busy && !empty;
  assign bit_end = clk_cnt == bit_cnt_w'(clks_per_bit - 1);
  assign tx      = tx_busy ? frame[0] : 1'b1;  // idle high

  always_ff @(posedge clk) begin
    if (push.valid && !full) begin
      fifo[wr_ptr[trace_ptr_w-1:0]] <= push.chr;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      tx_busy <= 1'b0;
      bit_idx <= '0;
      clk_cnt <= '0;
    end else begin
      if (push.valid && !full) wr_ptr <= wr_ptr + 1'b1;
      if (pop) begin
        rd_ptr  <= rd_ptr + 1'b1;
        tx_busy <= 1'b1;
        bit_idx <= '0;
        clk_cnt <= '0;
      end else if (tx_busy) begin
        if (bit_end) begin
          clk_cnt <= '0;
          if (bit_idx == 4'd9) tx_busy <= 1'b0;  // stop bit done
          else bit_idx <= bit_idx + 1'b1;
        end else begin
          clk_cnt <= clk_cnt + 1'b1;
        end
      end
    end
  end

  // lsb first, shift in ones
  always_ff @(posedge clk) begin
    if (pop) begin
      frame <= {1'b1, fifo[rd_ptr[trace_ptr_w-1:0]], 1'b0};
    end else if (tx_busy && bit_end) begin
      frame <= {1'b1, frame[9:1]};
    end
  end

  // fetcher has to honor full
  a_no_push_full : assert property (@(posedge clk) disable iff (!rst_n)
    push.valid |-> !full);

endmodule

/* verilog/fetch_top.sv */
`timescale 1ns/10ps

module fetch_top (
  input  logic               clk,
  input  logic               rst_n,
  input  fetch_pkg::wb_req_t wb_req,
  output fetch_pkg::wb_rsp_t wb_rsp,
  output fetch_pkg::insn_t   insn,
  output logic               insn_valid,
  input  logic               insn_ready,
  output logic               tx
);
  import fetch_pkg::*;

  mmu_cfg_t          cfg;
  ram_wr_t           ram_wr;
  tr_req_t           tr_req;
  tr_rsp_t           tr_rsp;
  logic [addr_w-1:0] rd_addr;   // physical read address
  logic [word_w-1:0] rd_data;
  trace_push_t       trace;
  logic              trace_full;
  logic              busy;
  logic              fault;

  mmu_config i_config (
    .clk(clk), .rst_n(rst_n), .wb_req(wb_req), .wb_rsp(wb_rsp),
    .busy(busy), .fault(fault), .cfg(cfg), .ram_wr(ram_wr)
  );

  mmu_walker i_walker (
    .clk(clk), .rst_n(rst_n), .cfg(cfg), .req(tr_req), .rsp(tr_rsp)
  );

  program_ram i_ram (
    .clk(clk), .wr(ram_wr), .rd_addr(rd_addr), .rd_data(rd_data)
  );

  insn_fetcher i_fetcher (
    .clk(clk), .rst_n(rst_n), .cfg(cfg), .tr_req(tr_req), .tr_rsp(tr_rsp),
    .rd_addr(rd_addr), .rd_data(rd_data), .insn(insn), .insn_valid(insn_valid),
    .insn_ready(insn_ready), .trace(trace), .trace_full(trace_full),
    .busy(busy), .fault(fault)
  );

  uart_trace i_uart (
    .clk(clk), .rst_n(rst_n), .push(trace), .full(trace_full), .tx(tx)
  );

endmodule

/* verif/tb_fetch_top.sv */
`timescale 1ns/10ps

module tb_fetch_top;
  import fetch_pkg::*;

  logic        clk = 1'b0;
  logic        rst_n = 1'b0;
  wb_req_t     wb_req = '0;
  wb_rsp_t     wb_rsp;
  insn_t       insn;
  logic        insn_valid;
  logic        insn_ready = 1'b0;
  logic        tx;

  // reference model of memory, segment chain and expected traffic
  logic [word_w-1:0] model_mem [64];
  logic [5:0]        model_seg [8];   // {next, page}
  logic [2:0]        model_start = '0;
  insn_t             exp_pairs [64];
  logic [5:0]        n_exp = '0;      // pairs expected so far
  logic [5:0]        pair_idx = '0;   // pairs handed off so far
  insn_t             exp_cur;
  insn_t             last_insn;
  logic [7:0]        exp_chars [$];

  int          errors = 0;
  int          strobe_cnt = 0;
  int          ack_cnt = 0;
  int unsigned lcg_state = 83435;

  logic        rx_active = 1'b0;      // uart decoder inside a frame
  int          rx_cnt = 0;
  logic [7:0]  rx_shift = '0;
  logic [7:0]  rx_exp;

  fetch_top i_dut (
    .clk(clk), .rst_n(rst_n), .wb_req(wb_req), .wb_rsp(wb_rsp),
    .insn(insn), .insn_valid(insn_valid), .insn_ready(insn_ready), .tx(tx)
  );

  always #10 clk = ~clk;  // 20 ns period

  function automatic int unsigned lcg_next(input int unsigned s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // page rule: page 0 sits in the start segment, others follow the links
  function automatic logic [6:0] translate(input logic [5:0] la);  // {fault, phys}
    logic [2:0] cur;
    logic [2:0] nxt;
    cur = model_start;
    if (la[5:3] == 3'd0) return {1'b0, cur, la[2:0]};
    for (int hop = 0; hop < 8; hop++) begin
      nxt = model_seg[cur][5:3];
      if (nxt == cur) return {1'b1, 6'h00};  // chain ends
      cur = nxt;
      if (model_seg[cur][2:0] == la[5:3]) return {1'b0, cur, la[2:0]};
    end
    return {1'b1, 6'h00};  // too many hops
  endfunction

  function automatic logic [7:0] letter_of(input logic [7:0] op);
    case (op)
      8'h01:   return "J";
      8'h02:   return "L";
      8'h03:   return "S";
      8'h04:   return "N";
      8'h0c:   return "P";
      default: return "X";
    endcase
  endfunction

  // opcode cycles through all letters, low byte carries the address
  function automatic logic [15:0] fill_word(input logic [5:0] a, input logic [7:0] salt);
    logic [7:0] op;
    case ((int'(a) + int'(salt)) % 7)
      0:       op = 8'h01;
      1:       op = 8'h02;
      2:       op = 8'h03;
      3:       op = 8'h04;
      4:       op = 8'h0c;
      5:       op = 8'h3a;
      default: op = 8'h90;
    endcase
    return {op, {a, 2'b00} ^ salt};
  endfunction

  always @(posedge clk) begin
    lcg_state  <= lcg_next(lcg_state);
    insn_ready <= lcg_state[17:16] != 2'b00;  // ready about 3 cycles in 4
  end

  assign exp_cur = exp_pairs[pair_idx];

  always @(posedge clk) begin
    last_insn <= insn;
    if (rst_n && insn_valid && insn_ready) pair_idx <= pair_idx + 6'd1;  // handoff
    if (wb_rsp.ack) ack_cnt <= ack_cnt + 1;
  end

  a_pair_match : assert property (@(posedge clk) disable iff (!rst_n)
    insn_valid && insn_ready |-> insn == exp_cur)
    else begin
      errors++;
      $display("Mismatch at %0t: insn got %h expected %h", $time, $sampled(insn),
               $sampled(exp_cur));
    end

  a_no_extra_pair : assert property (@(posedge clk) disable iff (!rst_n)
    insn_valid && insn_ready |-> pair_idx < n_exp)
    else begin
      errors++;
      $display("an extra instruction pair was delivered at %0t", $time);
    end

  a_valid_held : assert property (@(posedge clk) disable iff (!rst_n)
    insn_valid && !insn_ready |=> insn_valid)
    else begin
      errors++;
      $display("insn_valid dropped before insn_ready at %0t", $time);
    end

  a_insn_held : assert property (@(posedge clk) disable iff (!rst_n)
    insn_valid && !insn_ready |=> insn == last_insn)
    else begin
      errors++;
      $display("Mismatch at %0t: held insn got %h expected %h", $time, $sampled(insn),
               $sampled(last_insn));
    end

  a_ack_follows : assert property (@(posedge clk) disable iff (!rst_n)
    $rose(wb_req.stb) |=> wb_rsp.ack)
    else begin
      errors++;
      $display("strobe got no ack in the next cycle at %0t", $time);
    end

  a_ack_single : assert property (@(posedge clk) disable iff (!rst_n)
    wb_rsp.ack |=> !wb_rsp.ack)
    else begin
      errors++;
      $display("ack lasted more than one cycle at %0t", $time);
    end

  // uart decoder, samples in the middle of each bit
  always @(posedge clk) begin
    if (!rx_active) begin
      if (rst_n && tx === 1'b0) begin  // start bit seen
        rx_active <= 1'b1;
        rx_cnt    <= 2;
      end
    end else begin
      rx_cnt <= rx_cnt + 1;
      if (rx_cnt % clks_per_bit == clks_per_bit / 2) begin
        if (rx_cnt < clks_per_bit) begin
          assert (tx === 1'b0) else begin
            errors++;
            $display("start bit did not stay low at %0t", $time);
          end
        end else if (rx_cnt < 9 * clks_per_bit) begin
          rx_shift <= {tx, rx_shift[7:1]};  // lsb first
        end else begin
          rx_active <= 1'b0;
          // line must be back high before the next frame
          assert (tx === 1'b1) else begin
            errors++;
            $display("stop bit was low at %0t", $time);
          end
          if (exp_chars.size() == 0) begin
            errors++;
            $display("unexpected character %h on tx at %0t", rx_shift, $time);
          end else begin
            rx_exp = exp_chars.pop_front();
            assert (rx_shift == rx_exp) else begin
              errors++;
              $display("Mismatch at %0t: tx char got %s expected %s", $time, rx_shift, rx_exp);
            end
          end
        end
      end
    end
  end

  task automatic wb_access(input logic we, input logic [7:0] adr, input logic [15:0] dat,
                           output logic [15:0] rdat);
    int t;
    @(posedge clk);
    wb_req.cyc <= 1'b1;
    wb_req.stb <= 1'b1;
    wb_req.we  <= we;
    wb_req.adr <= adr;
    wb_req.dat <= dat;
    strobe_cnt++;
    t = 0;
    do begin
      @(posedge clk);
      t++;
    end while (!wb_rsp.ack && t < 20);
    if (!wb_rsp.ack) begin
      errors++;
      $display("no ack for address %h within 20 cycles at %0t", adr, $time);
    end
    rdat = wb_rsp.dat;
    wb_req.cyc <= 1'b0;  // drop strobe the cycle after ack
    wb_req.stb <= 1'b0;
    wb_req.we  <= 1'b0;
  endtask

  task automatic wb_write(input logic [7:0] adr, input logic [15:0] dat);
    logic [15:0] discard;
    wb_access(1'b1, adr, dat, discard);
    if (adr < seg_base) model_mem[adr[5:0]] = dat;  // mirror into model
    else if (adr < reg_start_seg) model_seg[adr[2:0]] = dat[5:0];
    else if (adr == reg_start_seg) model_start = dat[2:0];
  endtask

  task automatic wb_read(input logic [7:0] adr, output logic [15:0] rdat);
    wb_access(1'b0, adr, 16'h0000, rdat);
  endtask

  // logical words land at their translated physical slot
  task automatic load_program(input logic [7:0] salt, input int count);
    logic [5:0] la;
    logic [6:0] tr;
    for (int i = 0; i < count; i++) begin
      la = 6'(i);
      tr = translate(la);
      wb_write({2'b00, tr[5:0]}, fill_word(la, salt));
    end
  endtask

  task automatic run_fetch(input logic [5:0] start, input logic [5:0] stop);
    logic [5:0]  pc;
    logic [6:0]  tr1;
    logic [6:0]  tr2;
    logic        exp_fault;
    logic        ended;
    logic [15:0] rdat;
    int          t;
    exp_fault = 1'b0;
    ended     = 1'b0;
    pc        = start;
    exp_chars.push_back("G");
    while (!ended) begin
      tr1 = translate(pc);
      tr2 = translate(pc + 6'd1);
      if (tr1[6] || tr2[6]) begin  // no pair on a fault
        exp_chars.push_back("F");
        exp_fault = 1'b1;
        ended     = 1'b1;
      end else begin
        exp_pairs[n_exp] = {pc, model_mem[tr1[5:0]], model_mem[tr2[5:0]]};
        n_exp = n_exp + 6'd1;
        exp_chars.push_back(letter_of(model_mem[tr1[5:0]][15:8]));
        if (pc >= stop) begin
          exp_chars.push_back("E");
          ended = 1'b1;
        end else begin
          pc = pc + 6'd2;
        end
      end
    end
    wb_write(reg_fetch_start, {10'h000, start});
    wb_write(reg_fetch_end, {10'h000, stop});
    wb_read(reg_fetch_end, rdat);
    assert (rdat == {10'h000, stop}) else begin
      errors++;
      $display("Mismatch at %0t: fetch_end got %h expected %h", $time, rdat, stop);
    end
    wb_write(reg_ctrl, 16'h0001);  // go
    t = 0;
    do begin  // poll until busy clears
      wb_read(reg_ctrl, rdat);
      t++;
    end while (rdat[0] && t < 200);
    if (rdat[0]) begin
      errors++;
      $display("fetcher still busy after %0d status reads", t);
    end
    t = 0;
    while (exp_chars.size() != 0 && t < 4000) begin  // uart drain
      @(posedge clk);
      t++;
    end
    if (exp_chars.size() != 0) begin
      errors++;
      $display("%0d trace characters never arrived on tx", exp_chars.size());
    end
    assert (rdat == {14'h0000, exp_fault, 1'b0}) else begin
      errors++;
      $display("Mismatch at %0t: ctrl got %h expected %h", $time, rdat, {exp_fault, 1'b0});
    end
    assert (pair_idx == n_exp) else begin
      errors++;
      $display("Mismatch at %0t: pair count got %0d expected %0d", $time, pair_idx, n_exp);
    end
  endtask

  initial begin
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    // identity map, segment n holds page n
    for (int n = 0; n < 8; n++) begin
      wb_write(seg_base + 8'(n), {10'h000, 3'(n < 7 ? n + 1 : 7), 3'(n)});
    end
    wb_write(reg_start_seg, 16'h0000);
    load_program(8'h00, 64);
    run_fetch(6'd46, 6'd58);
    // chain 5 -> 2 -> 1, segment 1 self linked
    for (int n = 0; n < 8; n++) begin
      wb_write(seg_base + 8'(n), 16'h0000);
    end
    wb_write(seg_base + 8'd5, {10'h000, 3'd2, 3'd0});
    wb_write(seg_base + 8'd2, {10'h000, 3'd1, 3'd2});
    wb_write(seg_base + 8'd1, {10'h000, 3'd1, 3'd1});
    wb_write(reg_start_seg, 16'h0005);
    load_program(8'h5a, 24);
    run_fetch(6'd0, 6'd22);
    run_fetch(6'd16, 6'd30);  // page 3 missing from chain
    repeat (2) @(posedge clk);
    assert (ack_cnt == strobe_cnt) else begin
      errors++;
      $display("Mismatch at %0t: ack count got %0d expected %0d", $time, ack_cnt, strobe_cnt);
    end
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* vlog.f */
verilog/fetch_pkg.sv
verilog/mmu_config.sv
verilog/mmu_walker.sv
verilog/program_ram.sv
verilog/insn_fetcher.sv
verilog/uart_trace.sv
verilog/fetch_top.sv
verif/tb_fetch_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the fetch front end testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_fetch_top \
  -o tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "test failed" sim.log; then
  exit 1
fi
exit 0
